// ==== compile.f ====
+incdir+logic
+incdir+sim
logic/core_pkg.sv
logic/rf_read_if.sv
logic/pipe_reg.sv
logic/if_stage.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/register_file.sv
logic/core_top.sv
sim/tb_core.sv

// ==== logic/core_defines.svh ====
////////////////////
// Core widths, RV32I only
// Register count assumes x0 is included
////////////////////

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////
// Datapath
////////////////////

// Data and address width
`define CORE_XLEN 32

////////////////////
// Register file
////////////////////

// Integer registers, x0 counted
`define CORE_NUM_REGS 32
// Register index width
`define CORE_RF_AW 5

`endif

// ==== logic/core_pkg.sv ====
////////////////////
// Types shared by all pipeline stages
// Only integer ALU ops and LUI are decoded
////////////////////

`default_nettype none

`include "core_defines.svh"

package core_pkg;

  ////////////////////
  // Basic types
  ////////////////////

  // One data or address word
  typedef logic [`CORE_XLEN-1:0] word_t;
  // Register index
  typedef logic [`CORE_RF_AW-1:0] rf_addr_t;

  // ALU operations, PASS_B serves LUI
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // Major opcodes that the decoder keeps
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  ////////////////////
  // Pipeline payloads
  ////////////////////

  // Fetched word with its address
  typedef struct packed {
    word_t instr;
    word_t pc;
  } if_id_t;

  // Resolved operands and control for EX
  typedef struct packed {
    word_t    op_a;
    word_t    op_b;
    alu_op_e  alu_op;
    rf_addr_t rd;
    logic     we;
  } id_ex_t;

  // Result on its way to the register file
  typedef struct packed {
    word_t    result;
    rf_addr_t rd;
    logic     we;
  } ex_wb_t;

endpackage

`default_nettype wire

// ==== logic/core_top.sv ====
////////////////////
// Three-stage RV32I integer core, no branches or memory ops
// Fetch wait is the only stall source
////////////////////

`default_nettype none

module core_top import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  word_t    boot_addr_i,
  // Instruction fetch
  output logic     instr_req_o,
  output word_t    instr_addr_o,
  input  logic     instr_gnt_i,
  input  logic     instr_rvalid_i,
  input  word_t    instr_rdata_i,
  // Retirement
  output logic     wb_valid_o,
  output logic     wb_we_o,
  output rf_addr_t wb_waddr_o,
  output word_t    wb_wdata_o
);

  // Stage outputs and stage register outputs
  logic   if_valid, id_valid_q, id_valid, ex_valid_q, ex_valid, wb_valid_q;
  if_id_t if_id, if_id_q;
  id_ex_t id_ex, id_ex_q;
  ex_wb_t ex_wb, ex_wb_q;
  logic   rf_we;

  rf_read_if rf_rd ();

  ////////////////////
  // Fetch
  ////////////////////

  if_stage if_stage_i (
    .clk_i, .rst_n_i, .boot_addr_i,
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i,
    .valid_o (if_valid), .if_id_o (if_id)
  );

  pipe_reg #(.payload_t(if_id_t)) if_id_reg_i (
    .clk_i, .rst_n_i, .valid_i (if_valid), .payload_i (if_id),
    .valid_o (id_valid_q), .payload_o (if_id_q)
  );

  ////////////////////
  // Decode and execute
  ////////////////////

  id_stage id_stage_i (
    .valid_i (id_valid_q), .if_id_i (if_id_q), .rf (rf_rd.decoder),
    .ex_fwd_i (ex_wb), .ex_fwd_valid_i (ex_valid),
    .wb_fwd_i (ex_wb_q), .wb_fwd_valid_i (wb_valid_q),
    .valid_o (id_valid), .id_ex_o (id_ex)
  );

  pipe_reg #(.payload_t(id_ex_t)) id_ex_reg_i (
    .clk_i, .rst_n_i, .valid_i (id_valid), .payload_i (id_ex),
    .valid_o (ex_valid_q), .payload_o (id_ex_q)
  );

  ex_stage ex_stage_i (
    .valid_i (ex_valid_q), .id_ex_i (id_ex_q), .valid_o (ex_valid), .ex_wb_o (ex_wb)
  );

  pipe_reg #(.payload_t(ex_wb_t)) ex_wb_reg_i (
    .clk_i, .rst_n_i, .valid_i (ex_valid), .payload_i (ex_wb),
    .valid_o (wb_valid_q), .payload_o (ex_wb_q)
  );

  ////////////////////
  // Writeback
  ////////////////////

  // Stale payload must not write when the slot is empty
  assign rf_we = wb_valid_q && ex_wb_q.we;

  register_file register_file_i (
    .clk_i, .rst_n_i, .rf (rf_rd.regfile),
    .we_i (rf_we), .waddr_i (ex_wb_q.rd), .wdata_i (ex_wb_q.result)
  );

  assign wb_valid_o = wb_valid_q;
  assign wb_we_o    = rf_we;
  assign wb_waddr_o = ex_wb_q.rd;
  assign wb_wdata_o = ex_wb_q.result;

endmodule

`default_nettype wire

// ==== logic/ex_stage.sv ====
////////////////////
// Single-cycle ALU, no multiply or divide
////////////////////

`default_nettype none

module ex_stage import core_pkg::*; (
  input  logic   valid_i,
  input  id_ex_t id_ex_i,
  // To EX/WB register and decode forwarding
  output logic   valid_o,
  output ex_wb_t ex_wb_o
);

  logic [4:0] shamt;
  word_t      op_a;
  word_t      op_b;
  word_t      result;

  assign op_a = id_ex_i.op_a;
  assign op_b = id_ex_i.op_b;

  // Shift amount from low bits only
  assign shamt = op_b[4:0];

  ////////////////////
  // ALU
  ////////////////////

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      // Signed and unsigned compares give 0 or 1
      ALU_SLT:    result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   result = word_t'(op_a < op_b);
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      // Arithmetic shift keeps the sign
      ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      // LUI value already built in decode
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign valid_o        = valid_i;
  assign ex_wb_o.result = result;
  assign ex_wb_o.rd     = id_ex_i.rd;
  assign ex_wb_o.we     = id_ex_i.we;

endmodule

`default_nettype wire

// ==== logic/id_stage.sv ====
////////////////////
// Decodes OP, OP-IMM and LUI only
// Anything else leaves with write enable low
////////////////////

`default_nettype none

module id_stage import core_pkg::*; (
  input  logic   valid_i,
  input  if_id_t if_id_i,
  rf_read_if.decoder rf,
  // Forwarding sources
  input  ex_wb_t ex_fwd_i,
  input  logic   ex_fwd_valid_i,
  input  ex_wb_t wb_fwd_i,
  input  logic   wb_fwd_valid_i,
  // To ID/EX register
  output logic   valid_o,
  output id_ex_t id_ex_o
);

  // funct7 values for base and alternate ops
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rf_addr_t   rd;
  word_t      imm_i;
  word_t      imm_u;
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      op_b;
  alu_op_e    alu_op;
  logic       kept;

  // Base op selected by funct3
  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Youngest matching result wins over older ones
  function automatic word_t fwd_operand(input rf_addr_t rs, input word_t rf_val);
    if (ex_fwd_valid_i && ex_fwd_i.we && (ex_fwd_i.rd == rs)) begin
      return ex_fwd_i.result;
    end else if (wb_fwd_valid_i && wb_fwd_i.we && (wb_fwd_i.rd == rs)) begin
      return wb_fwd_i.result;
    end
    return rf_val;
  endfunction

  ////////////////////
  // Fields
  ////////////////////

  assign opcode = if_id_i.instr[6:0];
  assign rd     = if_id_i.instr[11:7];
  assign funct3 = if_id_i.instr[14:12];
  assign funct7 = if_id_i.instr[31:25];

  // rs1 and rs2 straight from their fixed slots
  assign rf.raddr_a = if_id_i.instr[19:15];
  assign rf.raddr_b = if_id_i.instr[24:20];

  // I-type sign extended, U-type upper 20 bits
  assign imm_i = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
  assign imm_u = {if_id_i.instr[31:12], 12'b0};

  always_comb begin
    rs1_val = fwd_operand(rf.raddr_a, rf.rdata_a);
    rs2_val = fwd_operand(rf.raddr_b, rf.rdata_b);
  end

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    alu_op = base_op(funct3);
    op_b   = rs2_val;
    kept   = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          kept = 1'b1;
        end else if (funct7 == F7_ALT) begin
          // Only SUB and SRA use the alternate encoding
          kept   = (funct3 == 3'b000) || (funct3 == 3'b101);
          alu_op = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
        end
      end
      OPC_OP_IMM: begin
        op_b = imm_i;
        if (funct3 == 3'b001) begin
          kept = (funct7 == F7_BASE);
        end else if (funct3 == 3'b101) begin
          // SRAI keeps funct7 in the immediate, EX masks it off
          kept   = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
        end else begin
          kept = 1'b1;
        end
      end
      OPC_LUI: begin
        kept   = 1'b1;
        alu_op = ALU_PASS_B;
        op_b   = imm_u;
      end
      default: begin
        kept = 1'b0;
      end
    endcase
  end

  // No back-pressure, item moves every cycle
  assign valid_o        = valid_i;
  assign id_ex_o.op_a   = rs1_val;
  assign id_ex_o.op_b   = op_b;
  assign id_ex_o.alu_op = alu_op;
  assign id_ex_o.rd     = rd;
  // x0 and unknown encodings never write
  assign id_ex_o.we     = kept && (rd != '0);

endmodule

`default_nettype wire

// ==== logic/if_stage.sv ====
////////////////////
// Sequential fetch only, PC steps by 4
// One request outstanding at a time
////////////////////

`default_nettype none

module if_stage import core_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  word_t  boot_addr_i,
  // Instruction memory
  output logic   instr_req_o,
  output word_t  instr_addr_o,
  input  logic   instr_gnt_i,
  input  logic   instr_rvalid_i,
  input  word_t  instr_rdata_i,
  // To IF/ID register
  output logic   valid_o,
  output if_id_t if_id_o
);

  // Request phase, then wait for response
  typedef enum logic {S_REQ, S_WAIT} fetch_state_e;

  fetch_state_e state_q, state_d;
  logic         req_q, req_d;
  word_t        pc_q;

  ////////////////////
  // Request FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    req_d   = req_q;
    case (state_q)
      S_REQ: begin
        // First cycle out of reset raises the request
        req_d = 1'b1;
        if (req_q && instr_gnt_i) begin
          state_d = S_WAIT;
          req_d   = 1'b0;
        end
      end
      S_WAIT: begin
        // Next request follows the response by one cycle
        if (instr_rvalid_i) begin
          state_d = S_REQ;
          req_d   = 1'b1;
        end
      end
      default: begin
        state_d = S_REQ;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= S_REQ;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      req_q   <= req_d;
    end
  end

  // PC moves on when its word has come back
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= boot_addr_i;
    end else if (valid_o) begin
      pc_q <= pc_q + word_t'(4);
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;

  // Response paired with the address that fetched it
  assign valid_o         = instr_rvalid_i && (state_q == S_WAIT);
  assign if_id_o.instr   = instr_rdata_i;
  assign if_id_o.pc      = pc_q;

  ////////////////////
  // Checks
  ////////////////////

  // Address held until the memory grants
  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  // Memory answers only what was asked
  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_rvalid_i |-> state_q == S_WAIT);

endmodule

`default_nettype wire

// ==== logic/pipe_reg.sv ====
////////////////////
// Stage register, no stall input
// Payload is held while valid_i is low
////////////////////

`default_nettype none

module pipe_reg import core_pkg::*; #(
  parameter type payload_t = word_t
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  payload_t payload_i,
  output logic     valid_o,
  output payload_t payload_o
);

  // Valid strobe, the only state cleared by reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload only moves with a real item
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      payload_o <= payload_i;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Upstream stage must hand over a fully known item
  a_payload_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> !$isunknown(payload_o));

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
////////////////////
// One write port, two combinational reads
// x0 has no storage and reads zero
////////////////////

`default_nettype none

`include "core_defines.svh"

module register_file import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  rf_read_if.regfile rf,
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  word_t    wdata_i
);

  // Storage for x1 upward
  word_t regs [1:`CORE_NUM_REGS-1];

  // All registers start at zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Read ports
  assign rf.rdata_a = (rf.raddr_a == '0) ? '0 : regs[rf.raddr_a];
  assign rf.rdata_b = (rf.raddr_b == '0) ? '0 : regs[rf.raddr_b];

  ////////////////////
  // Checks
  ////////////////////

  // Decode already drops writes to x0
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> waddr_i != '0);

endmodule

`default_nettype wire

// ==== logic/rf_read_if.sv ====
////////////////////
// Two read ports, data returned in the same cycle
////////////////////

`default_nettype none

`include "core_defines.svh"

interface rf_read_if;

  // Source register indices from decode
  logic [`CORE_RF_AW-1:0] raddr_a;
  logic [`CORE_RF_AW-1:0] raddr_b;
  // Read data, combinational
  logic [`CORE_XLEN-1:0]  rdata_a;
  logic [`CORE_XLEN-1:0]  rdata_b;

  // Decode side
  modport decoder (output raddr_a, output raddr_b, input rdata_a, input rdata_b);
  // Register file side
  modport regfile (input raddr_a, input raddr_b, output rdata_a, output rdata_b);

endinterface

`default_nettype wire

// ==== sim/tb_model.svh ====
////////////////////
// Stimulus and reference model, included inside tb_core only
// Uses word_t, rf_addr_t and opcodes from core_pkg
////////////////////

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////
// Random source
////////////////////

// 16-bit Fibonacci LFSR, taps 16 14 13 11
logic [15:0] lfsr_q;
// Last two destinations, targets for dependent sources
rf_addr_t    last_rd [0:1];
// Architectural registers of the reference, x0 never written
word_t       model_regs [0:`CORE_NUM_REGS-1];

// One step per bit taken
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  lfsr_q = {lfsr_q[14:0], fb};
  return fb;
endfunction

function automatic word_t rand_bits(input int n);
  word_t r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_bit()};
  end
  return r;
endfunction

// Half the sources point at a recent destination
function automatic rf_addr_t pick_src();
  word_t sel;
  sel = rand_bits(2);
  if (sel == 0) begin
    return last_rd[0];
  end else if (sel == 1) begin
    return last_rd[1];
  end
  sel = rand_bits(5);
  return sel[4:0];
endfunction

////////////////////
// Instruction generator
////////////////////

function automatic word_t gen_instr();
  word_t      r;
  word_t      kind;
  logic [2:0] f3;
  logic [6:0] f7;
  rf_addr_t   rd;
  rf_addr_t   rs1;
  rf_addr_t   rs2;
  word_t      instr;
  r    = rand_bits(5);
  rd   = r[4:0];
  rs1  = pick_src();
  rs2  = pick_src();
  r    = rand_bits(3);
  f3   = r[2:0];
  f7   = 7'h00;
  kind = rand_bits(3);
  if (kind == 0) begin
    // About 1 in 8 outside the kept set
    r = rand_bits(25);
    kind = rand_bits(2);
    case (kind[1:0])
      2'd0:    instr = {r[24:0], 7'b0000011};
      2'd1:    instr = {r[24:0], 7'b0100011};
      2'd2:    instr = {r[24:0], 7'b1100011};
      // M extension encoding on OP
      default: instr = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
    endcase
  end else begin
    kind = rand_bits(3);
    if (kind < 4) begin
      if (((f3 == 3'd0) || (f3 == 3'd5)) && lfsr_bit()) begin
        f7 = 7'h20;
      end
      instr = {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 7) begin
      if (f3 == 3'd1) begin
        instr = {7'h00, rs2, rs1, f3, rd, OPC_OP_IMM};
      end else if (f3 == 3'd5) begin
        // SRLI or SRAI, shift amount in the rs2 slot
        f7 = lfsr_bit() ? 7'h20 : 7'h00;
        instr = {f7, rs2, rs1, f3, rd, OPC_OP_IMM};
      end else begin
        r = rand_bits(12);
        instr = {r[11:0], rs1, f3, rd, OPC_OP_IMM};
      end
    end else begin
      r = rand_bits(20);
      instr = {r[19:0], rd, OPC_LUI};
    end
  end
  last_rd[1] = last_rd[0];
  last_rd[0] = rd;
  return instr;
endfunction

////////////////////
// Reference execution
////////////////////

// RV32I integer ops, alt selects SUB or SRA
function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
  case (f3)
    3'd0: begin
      if (alt) begin
        return a - b;
      end
      return a + b;
    end
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// Executes one instruction and updates the reference registers
task automatic model_step(input word_t instr, output logic exp_we, output word_t exp_data);
  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  rf_addr_t   rd;
  word_t      a;
  word_t      b;
  word_t      imm;
  logic       ok;
  opc      = instr[6:0];
  rd       = instr[11:7];
  f3       = instr[14:12];
  f7       = instr[31:25];
  a        = model_regs[instr[19:15]];
  b        = model_regs[instr[24:20]];
  imm      = {{20{instr[31]}}, instr[31:20]};
  ok       = 1'b0;
  exp_data = '0;
  case (opc)
    OPC_OP: begin
      ok = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
      exp_data = ref_alu(f3, f7 == 7'h20, a, b);
    end
    OPC_OP_IMM: begin
      if (f3 == 3'd1) begin
        ok = (f7 == 7'h00);
      end else if (f3 == 3'd5) begin
        ok = (f7 == 7'h00) || (f7 == 7'h20);
      end else begin
        ok = 1'b1;
      end
      exp_data = ref_alu(f3, (f3 == 3'd5) && (f7 == 7'h20), a, imm);
    end
    OPC_LUI: begin
      ok = 1'b1;
      exp_data = {instr[31:12], 12'h000};
    end
    default: begin
      ok = 1'b0;
    end
  endcase
  exp_we = ok && (rd != '0);
  if (exp_we) begin
    model_regs[rd] = exp_data;
  end
endtask

`endif

// ==== sim/tb_core.sv ====
////////////////////
// Random RV32I ALU program, 512 words from boot address
// Stops after 400 retirements
////////////////////

`default_nettype none

`include "core_defines.svh"

module tb_core import core_pkg::*; ();

  localparam int    NUM_RETIRE   = 400;
  localparam int    RESET_CYCLES = 10;
  localparam int    MAX_CYCLES   = NUM_RETIRE * 10 + RESET_CYCLES;
  localparam int    IMEM_WORDS   = 512;
  localparam int    WB_LATENCY   = 3;
  localparam word_t BOOT_ADDR    = 32'h0000_1000;

  // DUT ports
  logic     clk_i;
  logic     rst_n_i;
  word_t    boot_addr_i;
  logic     instr_req_o;
  word_t    instr_addr_o;
  logic     instr_gnt_i;
  logic     instr_rvalid_i;
  word_t    instr_rdata_i;
  logic     wb_valid_o;
  logic     wb_we_o;
  rf_addr_t wb_waddr_o;
  word_t    wb_wdata_o;

  // Memory model and bookkeeping
  word_t imem [0:IMEM_WORDS-1];
  int    cycle_cnt;
  int    retired;
  int    responses;
  int    mismatch_cnt;
  int    error_cnt;
  int    gnt_wait;
  int    resp_wait;
  int    resp_idx;
  logic  resp_pending;
  word_t exp_addr;
  // Edge numbers of responses still in the pipeline
  int    rv_cycles [$];

  `include "tb_model.svh"

  core_top dut0 (.*);

  ////////////////////
  // Compare and report
  ////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %08h expected %08h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input rf_addr_t got, input rf_addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %02h expected %02h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at cycle %0d: %s", cycle_cnt, msg);
    error_cnt++;
  endtask

  task automatic finish_run();
    $display("Summary: %0d retired, %0d responses, %0d mismatches, %0d other errors",
             retired, responses, mismatch_cnt, error_cnt);
    if ((mismatch_cnt == 0) && (error_cnt == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  ////////////////////
  // Instruction memory
  ////////////////////

  // Grant delay for the request that rises after this edge
  task automatic draw_grant_delay();
    word_t r;
    r        = rand_bits(2);
    gnt_wait = r;
    // Zero delay, grant already up in the first request cycle
    if (gnt_wait == 0) begin
      instr_gnt_i <= 1'b1;
    end
  endtask

  task automatic serve_memory();
    word_t r;
    // Single outstanding fetch
    if (instr_req_o && (resp_pending || instr_rvalid_i)) begin
      report_error("new fetch request while a response is outstanding");
    end
    // Response taken by the DUT at this edge, next request follows
    if (instr_rvalid_i) begin
      rv_cycles.push_back(cycle_cnt);
      responses++;
      draw_grant_delay();
    end
    instr_rvalid_i <= 1'b0;
    if (instr_req_o && instr_gnt_i) begin
      check_word("instr_addr_o", instr_addr_o, exp_addr);
      exp_addr = exp_addr + 32'd4;
      r = (instr_addr_o - BOOT_ADDR) >> 2;
      if (r >= IMEM_WORDS) begin
        report_error("fetch address outside the instruction memory");
        r = '0;
      end
      resp_idx     = r;
      resp_pending = 1'b1;
      r            = rand_bits(2);
      resp_wait    = r % 3;
      instr_gnt_i <= 1'b0;
    end else if (instr_req_o) begin
      // One to three cycles of request before the grant
      if (gnt_wait <= 1) begin
        instr_gnt_i <= 1'b1;
      end else begin
        gnt_wait--;
      end
    end
    // Data one to three cycles after grant
    if (resp_pending) begin
      if (resp_wait == 0) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= imem[resp_idx];
        resp_pending    = 1'b0;
      end else begin
        resp_wait--;
      end
    end
  endtask

  ////////////////////
  // Retirement
  ////////////////////

  task automatic check_retirement();
    int    t;
    logic  exp_we;
    word_t exp_data;
    word_t instr;
    // Oldest response overdue
    if ((rv_cycles.size() > 0) && (cycle_cnt - rv_cycles[0] > WB_LATENCY)) begin
      report_error("fetched instruction did not retire 3 cycles after its response");
      t = rv_cycles.pop_front();
    end
    if (wb_valid_o) begin
      if (rv_cycles.size() == 0) begin
        report_error("retirement with no fetched instruction in flight");
      end else begin
        t = rv_cycles.pop_front();
        if (cycle_cnt - t != WB_LATENCY) begin
          report_error($sformatf("retired %0d cycles after its response instead of 3",
                                 cycle_cnt - t));
        end
      end
      instr = imem[retired];
      model_step(instr, exp_we, exp_data);
      check_bit("wb_we_o", wb_we_o, exp_we);
      check_addr("wb_waddr_o", wb_waddr_o, instr[11:7]);
      // Data only matters when a register is written
      if (exp_we) begin
        check_word("wb_wdata_o", wb_wdata_o, exp_data);
      end
      retired++;
    end
  endtask

  ////////////////////
  // Clock, reset, run
  ////////////////////

  initial begin
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    resp_pending   = 1'b0;
    exp_addr       = BOOT_ADDR;
    lfsr_q         = 16'd42;
    last_rd[0]     = '0;
    last_rd[1]     = '0;
    for (int i = 0; i < `CORE_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    // Program in fetch order
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = gen_instr();
    end
  end

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (!rst_n_i) begin
      // Flops settle after the first reset edge
      if (cycle_cnt > 1) begin
        check_bit("instr_req_o", instr_req_o, 1'b0);
        check_bit("wb_valid_o", wb_valid_o, 1'b0);
      end
      if (cycle_cnt == RESET_CYCLES) begin
        rst_n_i <= 1'b1;
      end
    end else begin
      // Request still low in the first cycle out of reset
      if (cycle_cnt == RESET_CYCLES + 1) begin
        check_bit("instr_req_o", instr_req_o, 1'b0);
        draw_grant_delay();
      end
      serve_memory();
      check_retirement();
    end
    if (retired == NUM_RETIRE) begin
      finish_run();
    end else if (cycle_cnt >= MAX_CYCLES) begin
      report_error($sformatf("timeout with %0d of %0d instructions retired",
                             retired, NUM_RETIRE));
      finish_run();
    end
  end

endmodule

`default_nettype wire
